/* include/afu_config.svh */
`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// Memory command geometry
`define AFU_ADDR_W      64
`define AFU_TAG_W       4
`define AFU_LINE_BYTES  128

// Buffering and flow control
`define AFU_FIFO_DEPTH  4
`define AFU_CREDITS     8

// Job size
`define AFU_COUNT_W     16

// MMIO register map, one 64-bit register per offset
`define AFU_REG_BASE    2'd0
`define AFU_REG_COUNT   2'd1
`define AFU_REG_STATUS  2'd2
`define AFU_REG_ERROR   2'd3

`endif

/* src/afu_mem_pkg.sv */
`default_nettype none

`include "afu_config.svh"

package afu_mem_pkg;

  typedef logic [`AFU_ADDR_W-1:0] addr_t;
  typedef logic [`AFU_TAG_W-1:0]  tag_t;

  // Response codes as they appear on the wire
  typedef enum logic [1:0] {
    RESP_DONE  = 2'd0,
    RESP_FAULT = 2'd1
  } resp_code_e;

  // Read command, one cache line per command
  typedef struct packed {
    tag_t  tag;
    addr_t addr;
  } mem_command_t;

  // Response returned by tag, no ready on this path
  typedef struct packed {
    logic       valid;
    tag_t       tag;
    resp_code_e code;
  } mem_response_t;

endpackage

`default_nettype wire

/* src/afu_ctrl_pkg.sv */
`default_nettype none

`include "afu_config.svh"

package afu_ctrl_pkg;

  typedef logic [`AFU_COUNT_W-1:0] line_count_t;

  // Sticky error bits
  typedef logic [3:0] error_vec_t;
  localparam int ERR_FAULT    = 0;
  localparam int ERR_OVERFLOW = 1;
  localparam int ERR_TAG      = 2;
  localparam int ERR_MMIO     = 3;

  typedef enum logic [1:0] {
    JOB_IDLE,
    JOB_RUNNING,
    JOB_DONE
  } job_state_e;

  typedef struct packed {
    logic start;
    logic reset_job;
  } job_in_t;

  typedef struct packed {
    logic running;
    logic done;
  } job_out_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [1:0]  addr;
    logic [63:0] data;
  } mmio_req_t;

  typedef struct packed {
    logic        ack;
    logic [63:0] data;
  } mmio_resp_t;

endpackage

`default_nettype wire

/* src/job_control.sv */
`timescale 1ns/10ps
`default_nettype none

module job_control (
  input  wire                    clock,
  input  wire                    rst_n,
  input  wire afu_ctrl_pkg::job_in_t job_in,
  input  wire                    all_done,
  output afu_ctrl_pkg::job_out_t job_out,
  output logic                   running
);

  afu_ctrl_pkg::job_state_e state;
  logic                     done_q;

  //////////////////////////////////////////////////////////////////////
  // Job FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state  <= afu_ctrl_pkg::JOB_IDLE;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (job_in.reset_job) begin
        state <= afu_ctrl_pkg::JOB_IDLE;
      end else begin
        case (state)
          afu_ctrl_pkg::JOB_IDLE,
          afu_ctrl_pkg::JOB_DONE: begin
            if (job_in.start) state <= afu_ctrl_pkg::JOB_RUNNING;
          end
          afu_ctrl_pkg::JOB_RUNNING: begin
            // Start pulses are ignored here
            if (all_done) begin
              state  <= afu_ctrl_pkg::JOB_DONE;
              done_q <= 1'b1;
            end
          end
          default: state <= afu_ctrl_pkg::JOB_IDLE;
        endcase
      end
    end
  end

  assign running = (state == afu_ctrl_pkg::JOB_RUNNING);
  assign job_out = '{running: running, done: done_q};

  // Done pulse only after the job has left the running state
  assert property (@(posedge clock) disable iff (!rst_n)
    job_out.done |-> !job_out.running && $past(job_out.running));

endmodule

`default_nettype wire

/* src/mmio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "afu_config.svh"

module mmio_regs (
  input  wire                         clock,
  input  wire                         rst_n,
  input  wire afu_ctrl_pkg::mmio_req_t mmio_req,
  output afu_ctrl_pkg::mmio_resp_t    mmio_resp,
  input  wire                         running,
  input  wire afu_ctrl_pkg::line_count_t lines_done,
  input  wire afu_ctrl_pkg::error_vec_t  error_set,
  output afu_mem_pkg::addr_t          base_addr,
  output afu_ctrl_pkg::line_count_t   line_count
);

  afu_mem_pkg::addr_t        base_q;
  afu_ctrl_pkg::line_count_t count_q;
  afu_ctrl_pkg::error_vec_t  err_q;
  logic                      ack_q;
  logic [63:0]               rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Register writes and sticky errors
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      base_q  <= '0;
      count_q <= '0;
      err_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= mmio_req.valid;
      // Configuration is locked while a job runs
      if (mmio_req.valid && mmio_req.write && !running) begin
        if (mmio_req.addr == `AFU_REG_BASE) base_q <= mmio_req.data;
        if (mmio_req.addr == `AFU_REG_COUNT) count_q <= mmio_req.data[`AFU_COUNT_W-1:0];
      end
      // New error bits win over a clear in the same cycle
      if (mmio_req.valid && mmio_req.write && mmio_req.addr == `AFU_REG_ERROR)
        err_q <= (err_q & ~mmio_req.data[3:0]) | error_set;
      else
        err_q <= err_q | error_set;
    end
  end

  // Read data
  always_ff @(posedge clock) begin
    case (mmio_req.addr)
      `AFU_REG_BASE:   rdata_q <= base_q;
      `AFU_REG_COUNT:  rdata_q <= 64'(count_q);
      `AFU_REG_STATUS: rdata_q <= {47'b0, running, lines_done};
      default:         rdata_q <= 64'(err_q);
    endcase
  end

  assign mmio_resp  = '{ack: ack_q, data: rdata_q};
  assign base_addr  = base_q;
  assign line_count = count_q;

  assert property (@(posedge clock) disable iff (!rst_n)
    mmio_req.valid |=> mmio_resp.ack);
  assert property (@(posedge clock) disable iff (!rst_n)
    !mmio_req.valid |=> !mmio_resp.ack);

endmodule

`default_nettype wire

/* src/cu_read_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "afu_config.svh"

module cu_read_engine (
  input  wire                            clock,
  input  wire                            rst_n,
  input  wire                            running,
  input  wire afu_mem_pkg::addr_t        base_addr,
  input  wire afu_ctrl_pkg::line_count_t line_count,
  output afu_mem_pkg::mem_command_t      eng_cmd,
  output logic                           eng_valid,
  input  wire                            eng_ready,
  input  wire                            resp_accept,
  output afu_ctrl_pkg::line_count_t      lines_done,
  output logic                           all_done
);

  afu_ctrl_pkg::line_count_t issue_idx;
  afu_ctrl_pkg::line_count_t issue_next;
  logic                      running_q;
  logic                      finished;
  logic                      start_job;
  logic                      eng_fire;

  assign start_job  = running && !running_q;
  assign eng_fire   = eng_valid && eng_ready;
  assign issue_next = issue_idx + 1'b1;

  // Line address and tag follow the issue index
  assign eng_cmd.addr = base_addr +
                        afu_mem_pkg::addr_t'(issue_idx) * afu_mem_pkg::addr_t'(`AFU_LINE_BYTES);
  assign eng_cmd.tag  = issue_idx[`AFU_TAG_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Issue and completion tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      running_q  <= 1'b0;
      eng_valid  <= 1'b0;
      issue_idx  <= '0;
      lines_done <= '0;
      finished   <= 1'b0;
      all_done   <= 1'b0;
    end else begin
      running_q <= running;
      all_done  <= 1'b0;
      if (start_job) begin
        issue_idx  <= '0;
        lines_done <= '0;
        finished   <= 1'b0;
        eng_valid  <= (line_count != '0);
      end else if (!running) begin
        // Aborted job, stop offering commands
        eng_valid <= 1'b0;
      end else begin
        if (eng_fire) begin
          issue_idx <= issue_next;
          eng_valid <= (issue_next != line_count);
        end
        if (resp_accept) lines_done <= lines_done + 1'b1;
        if (!finished && lines_done == line_count) begin
          all_done <= 1'b1;
          finished <= 1'b1;
        end
      end
    end
  end

  // Held command must not move until the FIFO takes it
  assert property (@(posedge clock) disable iff (!rst_n || !running)
    eng_valid && !eng_ready |=> eng_valid && $stable(eng_cmd));

endmodule

`default_nettype wire

/* src/command_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "afu_config.svh"

module command_fifo #(
  parameter int DEPTH = `AFU_FIFO_DEPTH
) (
  input  wire                             clock,
  input  wire                             rst_n,
  input  wire afu_mem_pkg::mem_command_t  in_cmd,
  input  wire                             in_valid,
  output logic                            in_ready,
  output afu_mem_pkg::mem_command_t       out_cmd,
  output logic                            out_valid,
  input  wire                             out_ready
);

  localparam int PTR_W = $clog2(DEPTH);

  afu_mem_pkg::mem_command_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            count;
  logic                      wr_en;
  logic                      rd_en;

  assign in_ready  = (count != (PTR_W+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_cmd   = mem[rd_ptr];
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_ptr] <= in_cmd;
  end

  // Pointers wrap naturally for power-of-two depths
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en) count <= count + 1'b1;
      else if (rd_en && !wr_en) count <= count - 1'b1;
    end
  end

  // Full means the read and write pointers meet
  assert property (@(posedge clock) disable iff (!rst_n)
    (count == (PTR_W+1)'(DEPTH)) |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

/* src/command_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "afu_config.svh"

module command_issue (
  input  wire                             clock,
  input  wire                             rst_n,
  input  wire afu_mem_pkg::mem_command_t  fifo_cmd,
  input  wire                             fifo_valid,
  output logic                            fifo_ready,
  output afu_mem_pkg::mem_command_t       mem_cmd,
  output logic                            mem_cmd_valid,
  input  wire                             mem_cmd_ready,
  input  wire afu_mem_pkg::mem_response_t mem_resp,
  output logic                            resp_accept,
  output afu_ctrl_pkg::error_vec_t        error_set
);

  localparam int CREDIT_W = $clog2(`AFU_CREDITS + 1);

  logic [CREDIT_W-1:0]        credits;
  logic [2**`AFU_TAG_W-1:0]   outstanding;
  logic                       take;
  logic                       credit_full;
  logic                       credit_ret;
  logic                       tag_known;

  assign fifo_ready  = (credits != '0) && (!mem_cmd_valid || mem_cmd_ready);
  assign take        = fifo_valid && fifo_ready;
  assign credit_full = (credits == CREDIT_W'(`AFU_CREDITS));
  assign credit_ret  = mem_resp.valid && !credit_full;
  assign tag_known   = outstanding[mem_resp.tag];

  //////////////////////////////////////////////////////////////////////
  // Output register toward memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (take) mem_cmd <= fifo_cmd;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mem_cmd_valid <= 1'b0;
      credits       <= CREDIT_W'(`AFU_CREDITS);
      outstanding   <= '0;
    end else begin
      if (take) mem_cmd_valid <= 1'b1;
      else if (mem_cmd_ready) mem_cmd_valid <= 1'b0;
      case ({take, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
      if (mem_resp.valid) outstanding[mem_resp.tag] <= 1'b0;
      if (take) outstanding[fifo_cmd.tag] <= 1'b1;
    end
  end

  // Response checks, one-cycle pulses
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      resp_accept <= 1'b0;
      error_set   <= '0;
    end else begin
      resp_accept <= 1'b0;
      error_set   <= '0;
      if (mem_resp.valid) begin
        error_set[afu_ctrl_pkg::ERR_FAULT]    <= (mem_resp.code == afu_mem_pkg::RESP_FAULT);
        error_set[afu_ctrl_pkg::ERR_OVERFLOW] <= credit_full;
        error_set[afu_ctrl_pkg::ERR_TAG]      <= !tag_known;
        resp_accept <= tag_known && (mem_resp.code == afu_mem_pkg::RESP_DONE);
      end
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n)
    credits <= CREDIT_W'(`AFU_CREDITS));

endmodule

`default_nettype wire

/* src/afu_shell.sv */
`timescale 1ns/10ps
`default_nettype none

module afu_shell (
  input  wire                             clock,
  input  wire                             rst_n,
  input  wire afu_ctrl_pkg::job_in_t      job_in,
  output afu_ctrl_pkg::job_out_t          job_out,
  input  wire afu_ctrl_pkg::mmio_req_t    mmio_req,
  output afu_ctrl_pkg::mmio_resp_t        mmio_resp,
  output afu_mem_pkg::mem_command_t       mem_cmd,
  output logic                            mem_cmd_valid,
  input  wire                             mem_cmd_ready,
  input  wire afu_mem_pkg::mem_response_t mem_resp
);

  logic                      running;
  logic                      all_done;
  logic                      resp_accept;
  afu_mem_pkg::addr_t        base_addr;
  afu_ctrl_pkg::line_count_t line_count;
  afu_ctrl_pkg::line_count_t lines_done;
  afu_ctrl_pkg::error_vec_t  error_set;
  afu_mem_pkg::mem_command_t eng_cmd;
  afu_mem_pkg::mem_command_t fifo_cmd;
  logic                      eng_valid;
  logic                      eng_ready;
  logic                      fifo_valid;
  logic                      fifo_ready;

  //////////////////////////////////////////////////////////////////////
  // Control side
  //////////////////////////////////////////////////////////////////////

  job_control job_control_i (.clock(clock), .rst_n(rst_n), .job_in(job_in),
    .all_done(all_done), .job_out(job_out), .running(running));

  mmio_regs mmio_regs_i (.clock(clock), .rst_n(rst_n), .mmio_req(mmio_req),
    .mmio_resp(mmio_resp), .running(running), .lines_done(lines_done),
    .error_set(error_set), .base_addr(base_addr), .line_count(line_count));

  //////////////////////////////////////////////////////////////////////
  // Command path, engine to memory
  //////////////////////////////////////////////////////////////////////

  cu_read_engine cu_read_engine_i (.clock(clock), .rst_n(rst_n), .running(running),
    .base_addr(base_addr), .line_count(line_count), .eng_cmd(eng_cmd),
    .eng_valid(eng_valid), .eng_ready(eng_ready), .resp_accept(resp_accept),
    .lines_done(lines_done), .all_done(all_done));

  command_fifo command_fifo_i (.clock(clock), .rst_n(rst_n), .in_cmd(eng_cmd),
    .in_valid(eng_valid), .in_ready(eng_ready), .out_cmd(fifo_cmd),
    .out_valid(fifo_valid), .out_ready(fifo_ready));

  command_issue command_issue_i (.clock(clock), .rst_n(rst_n), .fifo_cmd(fifo_cmd),
    .fifo_valid(fifo_valid), .fifo_ready(fifo_ready), .mem_cmd(mem_cmd),
    .mem_cmd_valid(mem_cmd_valid), .mem_cmd_ready(mem_cmd_ready),
    .mem_resp(mem_resp), .resp_accept(resp_accept), .error_set(error_set));

endmodule

`default_nettype wire

/* testbench/afu_shell_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "afu_config.svh"

module afu_shell_tb;

  // Line counts of all jobs, used to size the watchdog
  localparam int TOTAL_LINES = 40 + 0 + 12 + 20;
  localparam int WATCHDOG_CYCLES = TOTAL_LINES * 64 + 2000;

  logic                       clock;
  logic                       rst_n;
  afu_ctrl_pkg::job_in_t      job_in;
  afu_ctrl_pkg::job_out_t     job_out;
  afu_ctrl_pkg::mmio_req_t    mmio_req;
  afu_ctrl_pkg::mmio_resp_t   mmio_resp;
  afu_mem_pkg::mem_command_t  mem_cmd;
  logic                       mem_cmd_valid;
  logic                       mem_cmd_ready;
  afu_mem_pkg::mem_response_t mem_resp;

  // Reference state of the current job
  string              job_name;
  logic [63:0]        job_base;
  int                 job_lines;
  int                 fault_line;
  int                 cmd_index;
  int                 resp_index;
  int                 inflight;
  int                 done_count;
  int                 value_errors;
  int                 protocol_errors;
  logic [31:0]        lfsr_state;
  int                 resp_wait;
  int                 stall_left;
  logic               stray_pending;
  afu_mem_pkg::tag_t  stray_tag;
  afu_mem_pkg::tag_t  pending_tags [$];

  afu_shell afu_shell_i (
    .clock(clock), .rst_n(rst_n), .job_in(job_in), .job_out(job_out),
    .mmio_req(mmio_req), .mmio_resp(mmio_resp), .mem_cmd(mem_cmd),
    .mem_cmd_valid(mem_cmd_valid), .mem_cmd_ready(mem_cmd_ready), .mem_resp(mem_resp)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int take_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model, ready gaps and responses in order
  //////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    mem_resp = '0;
    if (stray_pending) begin
      mem_resp = '{valid: 1'b1, tag: stray_tag, code: afu_mem_pkg::RESP_DONE};
      stray_pending = 1'b0;
    end else if (pending_tags.size() != 0) begin
      if (resp_wait != 0) begin
        resp_wait--;
      end else begin
        mem_resp.valid = 1'b1;
        mem_resp.tag   = pending_tags.pop_front();
        mem_resp.code  = (resp_index == fault_line) ? afu_mem_pkg::RESP_FAULT
                                                    : afu_mem_pkg::RESP_DONE;
        resp_index++;
        inflight--;
        resp_wait = take_bits(2);
      end
    end
    // Short random gaps plus an occasional long stall that fills the FIFO
    if (stall_left != 0) begin
      mem_cmd_ready = 1'b0;
      stall_left--;
    end else if (take_bits(4) == 0) begin
      mem_cmd_ready = 1'b0;
      stall_left = 10;
    end else begin
      mem_cmd_ready = (take_bits(2) != 0);
    end
    // Transfer happens on the coming rising edge
    if (mem_cmd_valid && mem_cmd_ready) begin
      if (cmd_index >= job_lines) begin
        protocol_errors++;
        $display("%s: command issued beyond the programmed line count", job_name);
      end
      check_value($sformatf("%s addr %0d", job_name, cmd_index),
                  job_base + 64'(cmd_index) * `AFU_LINE_BYTES, mem_cmd.addr);
      check_value($sformatf("%s tag %0d", job_name, cmd_index),
                  64'(cmd_index % 16), 64'(mem_cmd.tag));
      pending_tags.push_back(mem_cmd.tag);
      cmd_index++;
      inflight++;
    end
  end

  always @(negedge clock) begin
    if (job_out.done) done_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol assertions
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clock) disable iff (!rst_n)
    mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd))
  else begin
    protocol_errors++;
    $display("Held memory command changed or dropped before it was accepted");
  end

  assert property (@(posedge clock) disable iff (!rst_n) inflight <= `AFU_CREDITS)
  else begin
    protocol_errors++;
    $display("More than %0d commands outstanding at memory", `AFU_CREDITS);
  end

  assert property (@(posedge clock) disable iff (!rst_n)
    job_out.done |-> !job_out.running ##1 !job_out.done)
  else begin
    protocol_errors++;
    $display("Done pulse overlapped running or lasted more than one cycle");
  end

  task automatic mmio_access(input logic is_write, input logic [1:0] addr,
                             input logic [63:0] wdata, output logic [63:0] rdata);
    int n;
    @(negedge clock);
    mmio_req = '{valid: 1'b1, write: is_write, addr: addr, data: wdata};
    @(negedge clock);
    mmio_req = '0;
    n = 0;
    while (!mmio_resp.ack && n < 4) begin
      @(negedge clock);
      n++;
    end
    if (!mmio_resp.ack) begin
      protocol_errors++;
      $display("MMIO access at offset %0d was never acknowledged", addr);
    end
    rdata = mmio_resp.data;
  endtask

  task automatic load_job(input string name, input logic [63:0] base, input int lines,
                          input int fault);
    logic [63:0] rdata;
    mmio_access(1'b1, `AFU_REG_BASE, base, rdata);
    mmio_access(1'b1, `AFU_REG_COUNT, 64'(lines), rdata);
    job_name   = name;
    job_base   = base;
    job_lines  = lines;
    fault_line = fault;
    cmd_index  = 0;
    resp_index = 0;
  endtask

  task automatic pulse_start(input string name);
    @(negedge clock);
    job_in.start = 1'b1;
    @(negedge clock);
    job_in.start = 1'b0;
    check_value({name, " running after start"}, 1, 64'(job_out.running));
  endtask

  task automatic wait_for_done(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clock);
      seen = job_out.done;
      n++;
    end
  endtask

  // Full job with optional base rewrite while it runs
  task automatic run_job(input string name, input logic [63:0] base, input int lines,
                         input bit rewrite_base);
    logic [63:0] rdata;
    bit          seen;
    int          done_before;
    load_job(name, base, lines, -1);
    done_before = done_count;
    pulse_start(name);
    if (rewrite_base) begin
      repeat (8) @(negedge clock);
      check_value({name, " running at base write"}, 1, 64'(job_out.running));
      mmio_access(1'b1, `AFU_REG_BASE, ~base, rdata);
    end
    wait_for_done(lines * 64 + 200, seen);
    if (!seen) begin
      protocol_errors++;
      $display("%s: job never signalled done", name);
    end
    check_value({name, " responses at done"}, 64'(lines), 64'(resp_index));
    check_value({name, " commands at done"}, 64'(lines), 64'(cmd_index));
    repeat (4) @(negedge clock);
    check_value({name, " done pulses"}, 1, 64'(done_count - done_before));
    check_value({name, " running after done"}, 0, 64'(job_out.running));
    mmio_access(1'b0, `AFU_REG_STATUS, '0, rdata);
    check_value({name, " lines_done"}, 64'(lines), 64'(rdata[15:0]));
    mmio_access(1'b0, `AFU_REG_BASE, '0, rdata);
    check_value({name, " base register"}, base, rdata);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [63:0] rdata;
    int          done_before;
    int          n;
    rst_n = 1'b0;
    job_in = '0;
    mmio_req = '0;
    mem_cmd_ready = 1'b0;
    mem_resp = '0;
    lfsr_state = 32'hee9d_f129;
    job_name = "reset";
    job_base = '0;
    job_lines = 0;
    fault_line = -1;
    cmd_index = 0;
    resp_index = 0;
    inflight = 0;
    done_count = 0;
    value_errors = 0;
    protocol_errors = 0;
    resp_wait = 0;
    stall_left = 0;
    stray_pending = 1'b0;
    stray_tag = '0;
    repeat (16) @(negedge clock);
    rst_n = 1'b1;

    // Tag wrap and an address carry across bit 32
    run_job("wrap", 64'h0000_00ff_ffff_fe00, 40, 1'b0);
    run_job("empty", 64'h0000_0000_0001_0000, 0, 1'b0);

    // Fault on line 5, the job has to hang until reset_job
    load_job("fault", 64'h0000_0000_0000_8000, 12, 5);
    done_before = done_count;
    pulse_start("fault");
    n = 0;
    while (resp_index < 12 && n < 12 * 64) begin
      @(negedge clock);
      n++;
    end
    repeat (20) @(negedge clock);
    check_value("fault running held", 1, 64'(job_out.running));
    check_value("fault done pulses", 0, 64'(done_count - done_before));
    mmio_access(1'b0, `AFU_REG_ERROR, '0, rdata);
    check_value("fault error register", 64'h1, rdata);
    mmio_access(1'b0, `AFU_REG_STATUS, '0, rdata);
    check_value("fault lines_done", 64'd11, 64'(rdata[15:0]));
    @(negedge clock);
    job_in.reset_job = 1'b1;
    @(negedge clock);
    job_in.reset_job = 1'b0;
    check_value("fault running after reset_job", 0, 64'(job_out.running));
    mmio_access(1'b1, `AFU_REG_ERROR, '1, rdata);

    // Unknown tag while idle, credits are full so overflow is flagged too
    stray_tag = 4'h9;
    stray_pending = 1'b1;
    repeat (6) @(negedge clock);
    mmio_access(1'b0, `AFU_REG_ERROR, '0, rdata);
    check_value("stray tag error register", 64'h6, rdata);
    mmio_access(1'b1, `AFU_REG_ERROR, '1, rdata);
    mmio_access(1'b0, `AFU_REG_ERROR, '0, rdata);
    check_value("error register after clear", 64'h0, rdata);

    // All four offsets are mapped, so no bad MMIO address exists
    run_job("locked", 64'h0000_0000_0004_0000, 20, 1'b1);

    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
src/afu_mem_pkg.sv
src/afu_ctrl_pkg.sv
src/job_control.sv
src/mmio_regs.sv
src/cu_read_engine.sv
src/command_fifo.sv
src/command_issue.sv
src/afu_shell.sv
testbench/afu_shell_tb.sv
